// File: Bender.yml
package:
  name: fpu_exec_unit

sources:
  # packages first, fpuCmdPkg uses fpuFormatPkg
  - hdl/fpuFormatPkg.sv
  - hdl/fpuCmdPkg.sv
  - hdl/laneSelect.sv
  - hdl/floatWiden.sv
  - hdl/floatNarrow.sv
  - hdl/convertUnit.sv
  - hdl/issueStage.sv
  - hdl/resultSelect.sv
  - hdl/fpuExecUnit.sv
  - target: test
    files:
      - tb/fpuExec_assert.sv
      - tb/fpuExecCheck.sv
      - tb/fpuExecTb.sv

// File: filelist.f
hdl/fpuFormatPkg.sv
hdl/fpuCmdPkg.sv
hdl/laneSelect.sv
hdl/floatWiden.sv
hdl/floatNarrow.sv
hdl/convertUnit.sv
hdl/issueStage.sv
hdl/resultSelect.sv
hdl/fpuExecUnit.sv
tb/fpuExec_assert.sv
tb/fpuExecCheck.sv
tb/fpuExecTb.sv

// File: hdl/convertUnit.sv
// source half select and the four format converters
`default_nettype none

module convertUnit (
	input  fpuCmdPkg::laneCmd      picked,
	output fpuFormatPkg::convVals conv
);

	logic [31:0] singleSrc;
	logic [63:0] fromSingle;
	logic [63:0] fromHalf;
	logic [31:0] toSingle;
	logic [15:0] toHalf;

	assign singleSrc = picked.ext[3] ? picked.rs[63:32] : picked.rs[31:0];

	floatWiden #(
		.expWidth(fpuFormatPkg::singleExpWidth),
		.fracWidth(fpuFormatPkg::singleFracWidth),
		.bias(fpuFormatPkg::singleBias)
	) singleWiden (
		.narrowIn(singleSrc),
		.wideOut(fromSingle)
	);

	floatWiden #(
		.expWidth(fpuFormatPkg::halfExpWidth),
		.fracWidth(fpuFormatPkg::halfFracWidth),
		.bias(fpuFormatPkg::halfBias)
	) halfWiden (
		.narrowIn(picked.rs[15:0]), // half always from the low bits
		.wideOut(fromHalf)
	);

	floatNarrow #(
		.expWidth(fpuFormatPkg::singleExpWidth),
		.fracWidth(fpuFormatPkg::singleFracWidth),
		.bias(fpuFormatPkg::singleBias)
	) singleNarrow (
		.wideIn(picked.rs),
		.narrowOut(toSingle)
	);

	floatNarrow #(
		.expWidth(fpuFormatPkg::halfExpWidth),
		.fracWidth(fpuFormatPkg::halfFracWidth),
		.bias(fpuFormatPkg::halfBias)
	) halfNarrow (
		.wideIn(picked.rs),
		.narrowOut(toHalf)
	);

	assign conv = '{fromSingle: fromSingle, fromHalf: fromHalf,
		toSingle: toSingle, toHalf: toHalf};

endmodule

`default_nettype wire

// File: hdl/floatNarrow.sv
// double to narrow float converter, truncating
`default_nettype none

module floatNarrow #(
	parameter int expWidth = 8,
	parameter int fracWidth = 23,
	parameter int bias = 127
) (
	input  logic [63:0]                 wideIn,
	output logic [expWidth+fracWidth:0] narrowOut
);

	localparam logic signed [12:0] rebias = 13'(fpuFormatPkg::doubleBias - bias);
	localparam logic signed [12:0] expMax = 13'((1 << expWidth) - 1);
	localparam logic [expWidth-1:0] expOnes = {expWidth{1'b1}};

	logic               sign;
	logic [10:0]        expIn;
	logic [51:0]        fracIn;
	logic signed [12:0] expAdj;

	assign sign = wideIn[63];
	assign expIn = wideIn[62:52];
	assign fracIn = wideIn[51:0];

	// signed so that small exponents go negative
	assign expAdj = $signed({2'b00, expIn}) - rebias;

	always_comb begin
		if (expIn == 11'h7FF) begin
			if (fracIn == '0) begin
				narrowOut = {sign, expOnes, {fracWidth{1'b0}}};
			end else begin
				// quiet NaN keeps the top payload bits
				narrowOut = {sign, expOnes, 1'b1, fracIn[50 -: fracWidth-1]};
			end
		end else if (expAdj >= expMax) begin
			narrowOut = {sign, expOnes, {fracWidth{1'b0}}}; // overflow
		end else if (expAdj <= 13'sd0) begin
			// underflow, also catches double denormals
			narrowOut = {sign, {(expWidth+fracWidth){1'b0}}};
		end else begin
			narrowOut = {sign, expAdj[expWidth-1:0], fracIn[51 -: fracWidth]};
		end
	end

endmodule

`default_nettype wire

// File: hdl/floatWiden.sv
// narrow float to double converter, denormals flush to zero
`default_nettype none

module floatWiden #(
	parameter int expWidth = 8,
	parameter int fracWidth = 23,
	parameter int bias = 127
) (
	input  logic [expWidth+fracWidth:0] narrowIn,
	output logic [63:0]                 wideOut
);

	localparam logic [10:0] rebias = 11'(fpuFormatPkg::doubleBias - bias);
	localparam int fracPad = fpuFormatPkg::doubleFracWidth - fracWidth;

	logic                 sign;
	logic [expWidth-1:0]  expIn;
	logic [fracWidth-1:0] fracIn;
	logic [51:0]          fracWide;
	logic [10:0]          expWide;

	assign sign = narrowIn[expWidth+fracWidth];
	assign expIn = narrowIn[expWidth+fracWidth-1:fracWidth];
	assign fracIn = narrowIn[fracWidth-1:0];
	assign fracWide = {fracIn, {fracPad{1'b0}}}; // left-aligned

	always_comb begin
		expWide = 11'(expIn) + rebias;
		if (expIn == '0) begin
			wideOut = {sign, 63'd0}; // zero and denormal
		end else if (expIn == {expWidth{1'b1}}) begin
			wideOut = {sign, 11'h7FF, fracWide}; // inf / NaN keep payload
		end else begin
			wideOut = {sign, expWide, fracWide};
		end
	end

endmodule

`default_nettype wire

// File: hdl/fpuCmdPkg.sv
// opcode, condition-code, sub-op and status enums, lane and issued-command structs
`default_nettype none

package fpuCmdPkg;

	typedef enum logic [5:0] {
		opNop   = 6'h00,
		opFpu3  = 6'h18,
		opFldcx = 6'h19,
		opFstcx = 6'h1A
	} fpuOpcode;

	typedef enum logic [1:0] {
		ccAlways  = 2'd0,
		ccNever   = 2'd1,
		ccIfTrue  = 2'd2, // execute when SR.T set
		ccIfFalse = 2'd3  // execute when SR.T clear
	} condCode;

	// FLDCX sub-op lives in ext[2:0], ext[3] picks the upper single
	typedef enum logic [2:0] {
		ldSingle = 3'd0,
		ldMove   = 3'd1,
		ldHalf   = 3'd3
	} ldSubOp;

	typedef enum logic [3:0] {
		stSingle     = 4'd0,
		stMove       = 4'd1,
		stHalf       = 4'd3,
		stPackSingle = 4'd8
	} stSubOp;

	localparam logic [3:0] fpu3MoveOp = 4'h4;

	typedef enum logic [1:0] {
		statReady = 2'd0,
		statOk    = 2'd2
	} outStatus;

	// one command as offered per lane, 76 bits
	typedef struct packed {
		condCode     cond;
		fpuOpcode    opcode;
		logic [3:0]  ext;
		logic [63:0] rs;
	} laneCmd;

	// latched command plus converter results, needs fpuFormatPkg compiled first
	typedef struct packed {
		fpuOpcode              opcode;
		logic [3:0]            ext;
		logic [63:0]           rs;
		fpuFormatPkg::convVals conv;
		logic                  flush;
		condCode               cond;
		logic                  srT;
	} issuedCmd;

endpackage

`default_nettype wire

// File: hdl/fpuExecUnit.sv
// FPU conversion execute unit top level
`default_nettype none

module fpuExecUnit #(
	parameter bit laneBEnable = 1'b1
) (
	input  logic                clock,
	input  logic                reset,
	input  fpuCmdPkg::laneCmd    laneA,
	input  fpuCmdPkg::laneCmd    laneB,
	input  logic                srT,
	input  logic                braFlush,
	input  logic                exHold,
	output logic [63:0]         result,
	output fpuCmdPkg::outStatus status
);

	fpuCmdPkg::laneCmd      picked;
	fpuFormatPkg::convVals conv;
	fpuCmdPkg::issuedCmd    issued;

	laneSelect #(
		.laneBEnable(laneBEnable)
	) laneSel (
		.laneA(laneA),
		.laneB(laneB),
		.picked(picked)
	);

	convertUnit convert (
		.picked(picked),
		.conv(conv)
	);

	issueStage issue (
		.clock(clock),
		.reset(reset),
		.exHold(exHold),
		.braFlush(braFlush),
		.srT(srT),
		.picked(picked),
		.conv(conv),
		.issued(issued)
	);

	resultSelect resultSel (
		.issued(issued),
		.result(result),
		.status(status)
	);

endmodule

`default_nettype wire

// File: hdl/fpuFormatPkg.sv
// IEEE 754 format widths and biases, converted-values struct
`default_nettype none

package fpuFormatPkg;

	// binary64
	localparam int doubleExpWidth = 11;
	localparam int doubleFracWidth = 52;
	localparam int doubleBias = 1023;

	// binary32
	localparam int singleExpWidth = 8;
	localparam int singleFracWidth = 23;
	localparam int singleBias = 127;

	// binary16
	localparam int halfExpWidth = 5;
	localparam int halfFracWidth = 10;
	localparam int halfBias = 15;

	// all four conversions of one source value
	typedef struct packed {
		logic [63:0] fromSingle; // single to double
		logic [63:0] fromHalf;   // half to double
		logic [31:0] toSingle;   // double to single
		logic [15:0] toHalf;     // double to half
	} convVals;

endpackage

`default_nettype wire

// File: hdl/issueStage.sv
// command register with hold, branch flush and condition-code predication
`default_nettype none

module issueStage (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  exHold,
	input  logic                  braFlush,
	input  logic                  srT,
	input  fpuCmdPkg::laneCmd      picked,
	input  fpuFormatPkg::convVals conv,
	output fpuCmdPkg::issuedCmd    issued
);

	fpuCmdPkg::issuedCmd latched;
	logic opEnable;

	always_ff @(posedge clock) begin
		if (reset) begin
			latched <= '0; // opcode back to nop
		end else if (!exHold) begin
			latched.opcode <= picked.opcode;
			latched.ext <= picked.ext;
			latched.rs <= picked.rs;
			latched.conv <= conv;
			latched.flush <= braFlush;
			latched.cond <= picked.cond;
			latched.srT <= srT; // SR.T as seen with the command
		end
	end

	always_comb begin
		case (latched.cond)
			fpuCmdPkg::ccAlways:  opEnable = 1'b1;
			fpuCmdPkg::ccNever:   opEnable = 1'b0;
			fpuCmdPkg::ccIfTrue:  opEnable = latched.srT;
			fpuCmdPkg::ccIfFalse: opEnable = !latched.srT;
			default:              opEnable = 1'b0;
		endcase
		if (latched.flush)
			opEnable = 1'b0; // cancelled by a taken branch

		issued = latched;
		if (!opEnable)
			issued.opcode = fpuCmdPkg::opNop;
	end

endmodule

`default_nettype wire

// File: hdl/laneSelect.sv
// lane A / lane B command picker
`default_nettype none

module laneSelect #(
	parameter bit laneBEnable = 1'b1
) (
	input  fpuCmdPkg::laneCmd laneA,
	input  fpuCmdPkg::laneCmd laneB,
	output fpuCmdPkg::laneCmd picked
);

	logic laneAIsFpu;
	logic takeLaneB;

	// lane A has priority whenever it carries an FPU command
	assign laneAIsFpu = (laneA.opcode == fpuCmdPkg::opFpu3) ||
		(laneA.opcode == fpuCmdPkg::opFldcx) ||
		(laneA.opcode == fpuCmdPkg::opFstcx);

	assign takeLaneB = laneBEnable && !laneAIsFpu;

	assign picked = takeLaneB ? laneB : laneA;

endmodule

`default_nettype wire

// File: hdl/resultSelect.sv
// result mux by opcode and sub-op, status output
`default_nettype none

module resultSelect (
	input  fpuCmdPkg::issuedCmd issued,
	output logic [63:0]         result,
	output fpuCmdPkg::outStatus status
);

	fpuFormatPkg::convVals conv;

	assign conv = issued.conv;

	always_comb begin
		result = 64'd0;
		status = fpuCmdPkg::statOk;
		case (issued.opcode)
			fpuCmdPkg::opFldcx: begin
				case (fpuCmdPkg::ldSubOp'(issued.ext[2:0]))
					fpuCmdPkg::ldSingle: result = conv.fromSingle;
					fpuCmdPkg::ldHalf:   result = conv.fromHalf;
					fpuCmdPkg::ldMove:   result = issued.rs;
					default:             result = 64'd0;
				endcase
			end
			fpuCmdPkg::opFstcx: begin
				case (fpuCmdPkg::stSubOp'(issued.ext))
					fpuCmdPkg::stSingle:     result = {32'd0, conv.toSingle};
					fpuCmdPkg::stHalf:       result = {48'd0, conv.toHalf};
					fpuCmdPkg::stMove:       result = issued.rs;
					fpuCmdPkg::stPackSingle: result = {conv.toSingle, issued.rs[31:0]};
					default:                 result = 64'd0;
				endcase
			end
			fpuCmdPkg::opFpu3: begin
				// only the register move survives, others read zero
				if (issued.ext == fpuCmdPkg::fpu3MoveOp)
					result = issued.rs;
			end
			default: begin
				status = fpuCmdPkg::statReady; // nop, nothing executed
			end
		endcase
	end

endmodule

`default_nettype wire

// File: tb/fpuExecCheck.sv
// expected-output model, result and status comparison, error counters
`default_nettype none

module fpuExecCheck #(
	parameter bit laneBEnable = 1'b1
) (
	input  logic                clock,
	input  logic                reset,
	input  fpuCmdPkg::laneCmd   laneA,
	input  fpuCmdPkg::laneCmd   laneB,
	input  logic                srT,
	input  logic                braFlush,
	input  logic                exHold,
	input  logic [63:0]         result,
	input  fpuCmdPkg::outStatus status,
	output int                  checks,
	output int                  resultErrors,
	output int                  statusErrors
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		fpuCmdPkg::outStatus status;
		logic [63:0]         result;
	} outcome;

	outcome expected;
	string expTest;
	logic armed = 1'b0; // set by the first reset edge

	// narrow format to double, denormals become signed zero
	function automatic logic [63:0] toDouble(logic [31:0] val, int ew, int fw, int bias);
		int e;
		logic [63:0] frac;
		e = int'(val >> fw) & ((1 << ew) - 1);
		frac = 64'(val & ((32'd1 << fw) - 1)) << (52 - fw);
		if (e == 0)
			return {val[ew + fw], 63'd0};
		return {val[ew + fw], (e == (1 << ew) - 1) ? 11'h7ff : 11'(e - bias + 1023), frac[51:0]};
	endfunction

	// double to narrow format by truncation, right-aligned in 32 bits
	function automatic logic [31:0] fromDouble(logic [63:0] val, int ew, int fw, int bias);
		logic [31:0] sign;
		logic [31:0] ones;
		logic [31:0] frac;
		int e;
		sign = 32'(val[63]) << (ew + fw);
		ones = ((32'd1 << ew) - 1) << fw;
		frac = 32'(val[51:0] >> (52 - fw));
		e = int'(val[62:52]) - 1023 + bias;
		if (val[62:52] == 11'h7ff) // inf, or quiet NaN with top payload bits
			return (val[51:0] == 52'd0) ? sign | ones : sign | ones | frac | (32'd1 << (fw - 1));
		if (e >= (1 << ew) - 1)
			return sign | ones;
		if (e <= 0)
			return sign;
		return sign | (32'(e) << fw) | frac;
	endfunction

	function automatic logic isFpuOp(fpuCmdPkg::fpuOpcode op);
		return op inside {fpuCmdPkg::opFpu3, fpuCmdPkg::opFldcx, fpuCmdPkg::opFstcx};
	endfunction

	function automatic outcome expectedOutcome(fpuCmdPkg::laneCmd a, fpuCmdPkg::laneCmd b,
			logic t, logic flush);
		fpuCmdPkg::laneCmd cmd;
		logic run;
		outcome want;
		cmd = (isFpuOp(a.opcode) || !laneBEnable) ? a : b;
		case (cmd.cond)
			fpuCmdPkg::ccAlways: run = 1'b1;
			fpuCmdPkg::ccNever:  run = 1'b0;
			fpuCmdPkg::ccIfTrue: run = t;
			default:             run = !t;
		endcase
		want = '{status: fpuCmdPkg::statOk, result: 64'd0};
		if (flush || !run || !isFpuOp(cmd.opcode))
			want.status = fpuCmdPkg::statReady;
		else if (cmd.opcode == fpuCmdPkg::opFldcx) begin
			case (cmd.ext[2:0]) // 0 single, 1 move, 3 half
				3'd0: want.result = toDouble(cmd.ext[3] ? cmd.rs[63:32] : cmd.rs[31:0], 8, 23, 127);
				3'd1: want.result = cmd.rs;
				3'd3: want.result = toDouble(32'(cmd.rs[15:0]), 5, 10, 15);
				default: ;
			endcase
		end else if (cmd.opcode == fpuCmdPkg::opFstcx) begin
			case (cmd.ext) // 0 single, 1 move, 3 half, 8 packed single
				4'd0: want.result = 64'(fromDouble(cmd.rs, 8, 23, 127));
				4'd1: want.result = cmd.rs;
				4'd3: want.result = 64'(fromDouble(cmd.rs, 5, 10, 15));
				4'd8: want.result = {fromDouble(cmd.rs, 8, 23, 127), cmd.rs[31:0]};
				default: ;
			endcase
		end else if (cmd.ext == 4'd4)
			want.result = cmd.rs; // fpu3 register move
		return want;
	endfunction

	initial begin
		checks = 0;
		resultErrors = 0;
		statusErrors = 0;
	end

	always @(posedge clock) begin
		if (reset) begin
			expected <= '{status: fpuCmdPkg::statReady, result: 64'd0};
			expTest <= "reset";
			armed <= 1'b1;
		end else if (!exHold) begin
			expected <= expectedOutcome(laneA, laneB, srT, braFlush);
			expTest <= fpuExecTb.testName;
		end
	end

	// outputs are settled by the falling edge
	always @(negedge clock) begin
		if (armed) begin
			checks++;
			if (status !== expected.status) begin
				statusErrors++;
				$display("ERR %s: status expected %0d actual %0d at %0t",
					expTest, expected.status, status, $time);
			end
			if (expected.status == fpuCmdPkg::statOk && result !== expected.result) begin
				resultErrors++;
				$display("ERR %s: result expected %h actual %h at %0t",
					expTest, expected.result, result, $time);
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/fpuExecTb.sv
// testbench top: clock, reset, directed and random stimulus, timeout, DUT and checker
`default_nettype none

module fpuExecTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int randomCycles = 400;
	// directed part stays under 100 cycles, limit gives twice that margin
	localparam int cycleLimit = 2 * (randomCycles + 100);

	logic clock = 1'b0;
	logic reset, srT, braFlush, exHold;
	fpuCmdPkg::laneCmd laneA, laneB;
	logic [63:0] result;
	fpuCmdPkg::outStatus status;
	string testName = "idle";
	int checks, resultErrors, statusErrors;
	int cycles = 0;

	// zeros, denormals, inf, NaN, max normal, overflow and underflow picks
	logic [31:0] singles [6] = '{32'h3fc0_0000, 32'hc049_0fdb, 32'h0000_0123,
		32'h8000_0000, 32'hff80_0000, 32'h7fc0_0001};
	logic [15:0] halves [5] = '{16'h3c00, 16'h8001, 16'h7c00, 16'hfe01, 16'h7bff};
	logic [63:0] doubles [8] = '{64'h4009_21fb_5444_2d18, 64'hfff0_0000_0000_0000,
		64'h7ff8_0000_0000_0001, 64'h47f0_0000_0000_0000, 64'h3800_0000_0000_0000,
		64'h8000_0000_0000_0001, 64'h40f0_0000_0000_0000, 64'hbe00_0000_0000_0000};
	fpuCmdPkg::fpuOpcode opChoices [5] = '{fpuCmdPkg::opNop, fpuCmdPkg::opFpu3,
		fpuCmdPkg::opFldcx, fpuCmdPkg::opFstcx, fpuCmdPkg::fpuOpcode'(6'h05)};
	logic [3:0] extChoices [8] = '{4'd0, 4'd1, 4'd3, 4'd8, 4'd4, 4'd11, 4'd2, 4'd15};

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	fpuExecUnit #(.laneBEnable(1'b1)) DUT (.*);

	fpuExecCheck #(.laneBEnable(1'b1)) check (.*);

	function automatic fpuCmdPkg::laneCmd buildCmd(fpuCmdPkg::condCode cond,
			fpuCmdPkg::fpuOpcode opcode, logic [3:0] ext, logic [63:0] rs);
		return {cond, opcode, ext, rs};
	endfunction

	function automatic fpuCmdPkg::laneCmd randomCmd();
		logic [31:0] pick;
		logic [31:0] high;
		pick = $urandom;
		high = $urandom;
		return buildCmd(fpuCmdPkg::condCode'(pick[1:0]), opChoices[pick[4:2] % 5],
			extChoices[pick[7:5]], {high, $urandom});
	endfunction

	// one cycle of stimulus
	task automatic offer(string name, fpuCmdPkg::laneCmd a, fpuCmdPkg::laneCmd b,
			logic t, logic flush, logic hold);
		@(posedge clock);
		testName <= name;
		laneA <= a;
		laneB <= b;
		srT <= t;
		braFlush <= flush;
		exHold <= hold;
	endtask

	task automatic offerA(string name, fpuCmdPkg::fpuOpcode opcode, logic [3:0] ext,
			logic [63:0] rs);
		offer(name, buildCmd(fpuCmdPkg::ccAlways, opcode, ext, rs), '0, 1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		fpuCmdPkg::laneCmd a;
		fpuCmdPkg::laneCmd b;
		logic [31:0] bits;
		void'($urandom(32'h62c5_4fa9));
		reset = 1'b1;
		laneA = '0;
		laneB = '0;
		srT = 1'b0;
		braFlush = 1'b0;
		exHold = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		foreach (singles[i]) begin
			offerA("single to double low", fpuCmdPkg::opFldcx, 4'h0, {singles[5 - i], singles[i]});
			offerA("single to double high", fpuCmdPkg::opFldcx, 4'h8, {singles[i], singles[5 - i]});
		end
		foreach (halves[i])
			offerA("half to double", fpuCmdPkg::opFldcx, 4'h3, {48'h0123_4567_89ab, halves[i]});
		foreach (doubles[i]) begin
			offerA("double to single", fpuCmdPkg::opFstcx, 4'h0, doubles[i]);
			offerA("double to half", fpuCmdPkg::opFstcx, 4'h3, doubles[i]);
			offerA("packed single", fpuCmdPkg::opFstcx, 4'h8, doubles[i]);
		end
		offerA("fldcx move", fpuCmdPkg::opFldcx, 4'h1, 64'h0123_4567_89ab_cdef);
		offerA("fstcx move", fpuCmdPkg::opFstcx, 4'h1, 64'hfedc_ba98_7654_3210);
		offerA("fpu3 move", fpuCmdPkg::opFpu3, 4'h4, 64'h8000_0000_0000_0001);
		offerA("fpu3 dropped op", fpuCmdPkg::opFpu3, 4'h2, 64'h5555_aaaa_5555_aaaa);
		b = buildCmd(fpuCmdPkg::ccAlways, fpuCmdPkg::opFldcx, 4'h1, 64'h0b0b_0b0b_0b0b_0b0b);
		offer("lane B, A idle", '0, b, 1'b0, 1'b0, 1'b0);
		a = buildCmd(fpuCmdPkg::ccAlways, fpuCmdPkg::fpuOpcode'(6'h05), 4'h1, 64'h1);
		offer("lane B, A not FPU", a, b, 1'b0, 1'b0, 1'b0);
		a = buildCmd(fpuCmdPkg::ccAlways, fpuCmdPkg::opFpu3, 4'h4, 64'h0a0a_0a0a_0a0a_0a0a);
		offer("lane A wins", a, b, 1'b0, 1'b0, 1'b0);
		a = buildCmd(fpuCmdPkg::ccNever, fpuCmdPkg::opFldcx, 4'h1, 64'h0000_c0de_0000_c0de);
		offer("never", a, '0, 1'b1, 1'b0, 1'b0);
		a.cond = fpuCmdPkg::ccIfTrue;
		offer("if T, T set", a, '0, 1'b1, 1'b0, 1'b0);
		offer("if T, T clear", a, '0, 1'b0, 1'b0, 1'b0);
		a.cond = fpuCmdPkg::ccIfFalse;
		offer("if not T, T clear", a, '0, 1'b0, 1'b0, 1'b0);
		offer("if not T, T set", a, '0, 1'b1, 1'b0, 1'b0);
		a.cond = fpuCmdPkg::ccAlways;
		offer("branch flush", a, '0, 1'b0, 1'b1, 1'b0);
		offerA("before hold", fpuCmdPkg::opFstcx, 4'h1, 64'h1111_2222_3333_4444);
		repeat (3) offer("under hold", a, '0, 1'b0, 1'b0, 1'b1); // must never show up
		offerA("after hold", fpuCmdPkg::opFpu3, 4'h4, 64'h4444_3333_2222_1111);
		@(posedge clock);
		reset <= 1'b1;
		testName <= "reset mid-run";
		@(posedge clock);
		reset <= 1'b0;
		repeat (randomCycles) begin
			a = randomCmd();
			b = randomCmd();
			bits = $urandom;
			offer("random", a, b, bits[0], bits[3:1] == 3'd0, bits[6:4] == 3'd0);
		end
		offerA("drain", fpuCmdPkg::opNop, 4'h0, 64'd0);
		repeat (3) @(posedge clock);
		#1;
		$display("checks %0d, status errors %0d, result errors %0d, assertion failures %0d",
			checks, statusErrors, resultErrors, DUT.props.failCount);
		if (statusErrors + resultErrors + DUT.props.failCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/fpuExec_assert.sv
// concurrent assertions on status encoding, reset and hold behaviour of the execute unit
`default_nettype none

module fpuExecAssert (
	input logic                clock,
	input logic                reset,
	input logic                exHold,
	input logic [63:0]         result,
	input fpuCmdPkg::outStatus status
);
	timeunit 1ns;
	timeprecision 100ps;

	int failCount = 0;

	statusLegal: assert property (@(posedge clock) disable iff (reset)
		status inside {fpuCmdPkg::statReady, fpuCmdPkg::statOk})
	else begin
		failCount++;
		$error("status carries an undefined code");
	end

	// nothing is issued in the cycle after a reset edge
	readyAfterReset: assert property (@(posedge clock)
		reset |=> status == fpuCmdPkg::statReady)
	else begin
		failCount++;
		$error("status not ready in the cycle after reset");
	end

	holdFreezes: assert property (@(posedge clock) disable iff (reset)
		exHold |=> $stable(result) && $stable(status))
	else begin
		failCount++;
		$error("result or status changed while the stage was held");
	end

endmodule

bind fpuExecUnit fpuExecAssert props (.*);

`default_nettype wire
